// ==== project.f ====
rtl/fpu_seq_pkg.sv
rtl/offload_decoder.sv
rtl/seq_cfg_fifo.sv
rtl/loop_sequencer.sv
rtl/issue_arbiter.sv
rtl/fpu_seq_top.sv
bench/fpu_seq_tb.sv

// ==== Makefile ====
# Verilator simulation of the FPU offload sequencer

VERILATOR ?= verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := fpu_seq_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TESTBENCH PASSED

.PHONY: sim clean

# The log decides the result, the run itself always ends with $finish
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/fpu_seq_tb.sv ====
// Testbench for the FPU offload sequencer
// Reference model of loop replay and staggering, comparing process and test sequence

`timescale 1ns/1ps

module fpu_seq_tb;
  import fpu_seq_pkg::*;

  localparam int Timeout = 2000;

  typedef offload_req_t body_q_t[$];
  typedef issue_req_t   exp_q_t[$];

  logic         clk, rst;
  offload_req_t req;
  logic         req_valid, req_ready;
  issue_req_t   issue;
  logic         issue_valid, issue_ready;
  logic         rand_ready;

  exp_q_t     exp_q;
  issue_req_t exp_item;
  int         cmp_errs, wait_errs, errs_at_start, tests_run, tests_failed;

  fpu_seq_top #(
    .Depth(16)
  ) dut0 (
    .clk_i        (clk),
    .rst_i        (rst),
    .req_i        (req),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .issue_o      (issue),
    .issue_valid_o(issue_valid),
    .issue_ready_i(issue_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Sink stalls at random only while rand_ready is set
  initial begin
    logic stall_en;
    issue_ready = 1'b1;
    forever begin
      @(posedge clk);
      stall_en = rand_ready;
      #1;
      issue_ready = stall_en ? ($urandom % 4 != 0) : 1'b1;
    end
  end

  function automatic instr_t fp_op(input logic [4:0] f5, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [4:0] rd,
                                   input logic [2:0] f3, input logic [6:0] opc);
    return {f5, 2'b01, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic offload_req_t random_req(input instr_t op);
    offload_req_t r;
    r.op   = op;
    r.qid  = qid_t'($urandom);
    r.arga = {$urandom, $urandom};
    r.argb = {$urandom, $urandom};
    r.argc = $urandom;
    return r;
  endfunction

  function automatic loop_cfg_t loop_cfg(input logic outer, input int rpt, input int smax,
                                         input logic [3:0] mask);
    loop_cfg_t c;
    c              = '0;
    c.is_outer     = outer;
    c.max_rpt      = rpt_t'(rpt);
    c.stagger_max  = stagger_t'(smax);
    c.stagger_mask = mask;
    return c;
  endfunction

  // Header carries outer at bit 7, mask at 11:8, stagger at 14:12 and max_inst at 23:20
  // The repeat count travels in arga
  function automatic offload_req_t frep_req(input loop_cfg_t cfg);
    offload_req_t r;
    r = random_req({8'd0, cfg.max_inst, 5'd0, cfg.stagger_max, cfg.stagger_mask,
                    cfg.is_outer, OpcodeFrep});
    r.arga = {48'd0, cfg.max_rpt};
    return r;
  endfunction

  function automatic instr_t add_stagger(input instr_t op, input logic [3:0] mask,
                                         input int stg);
    logic [4:0] s;
    s = 5'(stg);
    if (mask[0]) op[11:7] = op[11:7] + s;
    if (mask[1]) op[19:15] = op[19:15] + s;
    if (mask[2]) op[24:20] = op[24:20] + s;
    if (mask[3]) op[31:27] = op[31:27] + s;
    return op;
  endfunction

  // Expected issue order of one loop from the replay rules
  function automatic exp_q_t model_loop(input loop_cfg_t cfg, input body_q_t body);
    exp_q_t     res;
    issue_req_t item;
    int         n_inst, n_rpt, n_outer, n_inner, idx, rpt, stg, count;
    n_inst  = body.size();
    n_rpt   = int'(cfg.max_rpt) + 1;
    n_outer = cfg.is_outer ? n_rpt : n_inst;
    n_inner = cfg.is_outer ? n_inst : n_rpt;
    count   = 0;
    for (int a = 0; a < n_outer; a++) begin
      for (int b = 0; b < n_inner; b++) begin
        idx = cfg.is_outer ? b : a;
        rpt = cfg.is_outer ? a : b;
        // Outer loops stagger per body pass and inner loops per issued copy
        stg = (cfg.is_outer ? rpt : count) % (int'(cfg.stagger_max) + 1);
        item          = '0;
        item.req.op   = add_stagger(body[idx].op, cfg.stagger_mask, stg);
        item.req.argc = body[idx].argc;
        item.repd     = rpt != 0;
        res.push_back(item);
        count++;
      end
    end
    return res;
  endfunction

  task automatic send_req(input offload_req_t r);
    int   cycles;
    logic taken;
    req       = r;
    req_valid = 1'b1;
    cycles    = 0;
    taken     = 1'b0;
    while (!taken && cycles < Timeout) begin
      @(negedge clk);
      taken = req_ready;
      @(posedge clk);
      #1;
      cycles++;
    end
    req_valid = 1'b0;
    if (!taken) begin
      $display("Timeout: request with op %h was never accepted", r.op);
      wait_errs++;
    end
  endtask

  task automatic send_direct(input offload_req_t r);
    issue_req_t item;
    item.req  = r;
    item.repd = 1'b0;
    exp_q.push_back(item);
    send_req(r);
  endtask

  task automatic run_loop(input loop_cfg_t cfg, input body_q_t body, input logic with_header);
    exp_q_t    items;
    loop_cfg_t hdr_cfg;
    hdr_cfg          = cfg;
    hdr_cfg.max_inst = inst_cnt_t'(body.size() - 1);
    items            = model_loop(hdr_cfg, body);
    foreach (items[i]) exp_q.push_back(items[i]);
    if (with_header) send_req(frep_req(hdr_cfg));
    foreach (body[i]) send_req(body[i]);
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < Timeout) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: %0d expected instructions were never issued", exp_q.size());
      wait_errs++;
      exp_q.delete();
    end
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic close_test(input string name);
    int errs;
    wait_drain();
    errs = cmp_errs + wait_errs - errs_at_start;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %0d %s: %0d errors", tests_run, name, errs);
    errs_at_start = cmp_errs + wait_errs;
  endtask

  // Pops one expected entry per issue transfer in mid-cycle
  always @(negedge clk) begin
    if (!rst && issue_valid && issue_ready) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected issue of op %h while nothing was expected", issue.req.op);
        cmp_errs++;
      end else begin
        exp_item = exp_q.pop_front();
        if (issue.req.op !== exp_item.req.op) begin
          $display("ERR issue_o.op got %h expected %h", issue.req.op, exp_item.req.op);
          cmp_errs++;
        end
        if (issue.req.argc !== exp_item.req.argc) begin
          $display("ERR issue_o.argc got %h expected %h", issue.req.argc, exp_item.req.argc);
          cmp_errs++;
        end
        if (issue.req.qid !== exp_item.req.qid) begin
          $display("ERR issue_o.qid got %h expected %h", issue.req.qid, exp_item.req.qid);
          cmp_errs++;
        end
        if (issue.req.arga !== exp_item.req.arga || issue.req.argb !== exp_item.req.argb) begin
          $display("ERR issue_o.arga/argb got %h/%h expected %h/%h", issue.req.arga,
                   issue.req.argb, exp_item.req.arga, exp_item.req.argb);
          cmp_errs++;
        end
        if (issue.repd !== exp_item.repd) begin
          $display("ERR issue_o.repd got %h expected %h", issue.repd, exp_item.repd);
          cmp_errs++;
        end
      end
    end
  end

  initial begin
    body_q_t body;
    void'($urandom(65));
    rst           = 1'b1;
    req           = '0;
    req_valid     = 1'b0;
    rand_ready    = 1'b0;
    cmp_errs      = 0;
    wait_errs     = 0;
    errs_at_start = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    // feq.d, fmv.x.d, csrrs on fcsr
    send_direct(random_req(fp_op(5'b10100, 5'd2, 5'd1, 5'd3, 3'b010, OpcodeOpFp)));
    send_direct(random_req(fp_op(5'b11100, 5'd0, 5'd7, 5'd9, 3'b000, OpcodeOpFp)));
    send_direct(random_req({12'h003, 5'd0, 3'b010, 5'd10, OpcodeSystem}));
    close_test("direct pass-through");

    body = {};
    body.push_back(random_req(fp_op(5'b00000, 5'd2, 5'd1, 5'd3, 3'b111, OpcodeOpFp)));
    body.push_back(random_req(fp_op(5'b00010, 5'd5, 5'd4, 5'd6, 3'b111, OpcodeOpFp)));
    body.push_back(random_req(fp_op(5'b00001, 5'd8, 5'd7, 5'd9, 3'b111, OpcodeOpFp)));
    run_loop('0, body, 1'b0);
    close_test("plain buffered instructions");

    body = {};
    body.push_back(random_req(fp_op(5'b00000, 5'd12, 5'd11, 5'd13, 3'b111, OpcodeOpFp)));
    body.push_back(random_req(fp_op(5'b00010, 5'd15, 5'd14, 5'd16, 3'b111, OpcodeOpFp)));
    run_loop(loop_cfg(1'b0, 3, 0, 4'b0000), body, 1'b1);
    close_test("inner frep");

    body = {};
    body.push_back(random_req(fp_op(5'b00000, 5'd2, 5'd1, 5'd3, 3'b111, OpcodeOpFp)));
    body.push_back(random_req(fp_op(5'b00011, 5'd5, 5'd4, 5'd6, 3'b111, OpcodeOpFp)));
    body.push_back(random_req(fp_op(5'b00001, 5'd8, 5'd7, 5'd9, 3'b111, OpcodeOpFp)));
    run_loop(loop_cfg(1'b1, 2, 0, 4'b0000), body, 1'b1);
    close_test("outer frep");

    // Second body entry has rd 30 so the stagger wraps modulo 32
    body = {};
    body.push_back(random_req(fp_op(5'b00010, 5'd12, 5'd8, 5'd4, 3'b111, OpcodeOpFp)));
    body.push_back(random_req(fp_op(5'b00001, 5'd3, 5'd31, 5'd30, 3'b111, OpcodeOpFp)));
    run_loop(loop_cfg(1'b1, 3, 2, 4'b0011), body, 1'b1);
    close_test("register staggering");

    rand_ready = 1'b1;
    body = {};
    body.push_back(random_req(fp_op(5'd20, 5'd2, 5'd1, 5'd3, 3'b111, 7'b1000011)));
    body.push_back(random_req(fp_op(5'b00000, 5'd5, 5'd4, 5'd6, 3'b111, OpcodeOpFp)));
    body.push_back(random_req(fp_op(5'b00011, 5'd8, 5'd7, 5'd9, 3'b111, OpcodeOpFp)));
    run_loop(loop_cfg(1'b0, 2, 3, 4'b1101), body, 1'b1);
    send_direct(random_req(fp_op(5'b11100, 5'd0, 5'd6, 5'd11, 3'b000, OpcodeOpFp)));
    close_test("random back-pressure and ordering");
    rand_ready = 1'b0;

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
             cmp_errs + wait_errs);
    if (cmp_errs + wait_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/fpu_seq_top.sv ====
// FPU offload sequencer top level
// Decoder, loop sequencer and issue arbiter

`timescale 1ns/1ps

module fpu_seq_top #(
  parameter int unsigned Depth = 16
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  fpu_seq_pkg::offload_req_t req_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  output fpu_seq_pkg::issue_req_t   issue_o,
  output logic                      issue_valid_o,
  input  logic                      issue_ready_i
);
  import fpu_seq_pkg::*;

  loop_cfg_t cfg;
  logic      cfg_valid, cfg_ready;
  logic      body_valid, body_ready;
  logic      direct_valid, direct_ready;
  instr_t    seq_op;
  addr_t     seq_argc;
  logic      seq_repd, seq_valid, seq_ready;
  logic      buf_busy;

  offload_decoder i_decoder (
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .cfg_o         (cfg),
    .cfg_valid_o   (cfg_valid),
    .cfg_ready_i   (cfg_ready),
    .body_valid_o  (body_valid),
    .body_ready_i  (body_ready),
    .direct_valid_o(direct_valid),
    .direct_ready_i(direct_ready)
  );

  loop_sequencer #(
    .Depth(Depth)
  ) i_sequencer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cfg_i       (cfg),
    .cfg_valid_i (cfg_valid),
    .cfg_ready_o (cfg_ready),
    .body_op_i   (req_i.op),
    .body_argc_i (req_i.argc),
    .body_valid_i(body_valid),
    .body_ready_o(body_ready),
    .seq_op_o    (seq_op),
    .seq_argc_o  (seq_argc),
    .seq_repd_o  (seq_repd),
    .seq_valid_o (seq_valid),
    .seq_ready_i (seq_ready),
    .buf_busy_o  (buf_busy)
  );

  issue_arbiter i_arbiter (
    .req_i         (req_i),
    .direct_valid_i(direct_valid),
    .direct_ready_o(direct_ready),
    .seq_op_i      (seq_op),
    .seq_argc_i    (seq_argc),
    .seq_repd_i    (seq_repd),
    .seq_valid_i   (seq_valid),
    .seq_ready_o   (seq_ready),
    .buf_busy_i    (buf_busy),
    .issue_o       (issue_o),
    .issue_valid_o (issue_valid_o),
    .issue_ready_i (issue_ready_i)
  );

endmodule

// ==== rtl/issue_arbiter.sv ====
// Issue arbiter
// Picks sequenced or direct instructions and keeps program order

`timescale 1ns/1ps

module issue_arbiter (
  input  fpu_seq_pkg::offload_req_t req_i,
  input  logic                      direct_valid_i,
  output logic                      direct_ready_o,
  input  fpu_seq_pkg::instr_t       seq_op_i,
  input  fpu_seq_pkg::addr_t        seq_argc_i,
  input  logic                      seq_repd_i,
  input  logic                      seq_valid_i,
  output logic                      seq_ready_o,
  input  logic                      buf_busy_i,
  output fpu_seq_pkg::issue_req_t   issue_o,
  output logic                      issue_valid_o,
  input  logic                      issue_ready_i
);
  import fpu_seq_pkg::*;

  offload_req_t seq_req;

  // Buffered instructions carry no operands and no destination tag
  always_comb begin
    seq_req      = '0;
    seq_req.op   = seq_op_i;
    seq_req.argc = seq_argc_i;
  end

  // Direct requests wait until the buffer has drained
  always_comb begin
    if (buf_busy_i) begin
      issue_o.req    = seq_req;
      issue_o.repd   = seq_repd_i;
      issue_valid_o  = seq_valid_i;
      seq_ready_o    = issue_ready_i;
      direct_ready_o = 1'b0;
    end else begin
      issue_o.req    = req_i;
      issue_o.repd   = 1'b0;
      issue_valid_o  = direct_valid_i;
      seq_ready_o    = 1'b0;
      direct_ready_o = issue_ready_i;
    end
  end

endmodule

// ==== rtl/loop_sequencer.sv ====
// Loop sequencer with ring buffer, config FIFO and loop counters
// Replays buffered FP instructions as inner or outer loops with register staggering

`timescale 1ns/1ps

module loop_sequencer #(
  parameter int unsigned Depth = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  fpu_seq_pkg::loop_cfg_t cfg_i,
  input  logic                   cfg_valid_i,
  output logic                   cfg_ready_o,
  input  fpu_seq_pkg::instr_t    body_op_i,
  input  fpu_seq_pkg::addr_t     body_argc_i,
  input  logic                   body_valid_i,
  output logic                   body_ready_o,
  output fpu_seq_pkg::instr_t    seq_op_o,
  output fpu_seq_pkg::addr_t     seq_argc_o,
  output logic                   seq_repd_o,
  output logic                   seq_valid_o,
  input  logic                   seq_ready_i,
  output logic                   buf_busy_o
);
  import fpu_seq_pkg::*;

  // Depth is a power of two so the pointers wrap on their own
  localparam int unsigned IdxWidth = $clog2(Depth);
  localparam int unsigned PtrWidth = IdxWidth + 1;

  typedef logic [PtrWidth-1:0] ptr_t;

  typedef struct packed {
    instr_t op;
    addr_t  argc;
  } body_entry_t;

  typedef struct packed {
    loop_cfg_t cfg;
    ptr_t      base;
  } cfg_entry_t;

  body_entry_t mem_q [Depth];
  body_entry_t rd_entry;
  ptr_t        wr_ptr_q, base_ptr_q, rd_ptr;
  logic        buf_full, rd_empty, body_push;

  cfg_entry_t fifo_in, fifo_out;
  logic       fifo_full, fifo_empty, fifo_pop;
  logic       cfg_active;
  loop_cfg_t  curr_cfg;

  inst_cnt_t inst_cnt_q, inst_cnt_d;
  rpt_t      rpt_cnt_q, rpt_cnt_d;
  stagger_t  stg_cnt_q, stg_cnt_d, stg_step;
  logic      inst_last, rpt_last, seq_fire, loop_end;

  // Ring buffer, one extra pointer bit separates full from empty
  assign body_push    = body_valid_i & body_ready_o;
  assign body_ready_o = ~buf_full;
  assign buf_full     = (wr_ptr_q ^ base_ptr_q) == ptr_t'(Depth);
  assign buf_busy_o   = wr_ptr_q != base_ptr_q;
  assign rd_ptr       = base_ptr_q + ptr_t'(inst_cnt_q);
  assign rd_empty     = rd_ptr == wr_ptr_q;
  assign rd_entry     = mem_q[rd_ptr[IdxWidth-1:0]];

  always_ff @(posedge clk_i) begin
    if (body_push) begin
      mem_q[wr_ptr_q[IdxWidth-1:0]] <= '{op: body_op_i, argc: body_argc_i};
    end
  end

  // A new config is tagged with the slot where its body will start
  assign fifo_in.cfg  = cfg_i;
  assign fifo_in.base = wr_ptr_q;
  assign cfg_ready_o  = ~fifo_full;

  seq_cfg_fifo #(
    .Depth(Depth)
  ) i_cfg_fifo (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .data_i (fifo_in),
    .push_i (cfg_valid_i & cfg_ready_o),
    .full_o (fifo_full),
    .data_o (fifo_out),
    .empty_o(fifo_empty),
    .pop_i  (fifo_pop)
  );

  // Without a matching config each instruction issues once
  assign cfg_active = ~fifo_empty & (fifo_out.base == base_ptr_q);

  always_comb begin
    curr_cfg = fifo_out.cfg;
    if (!cfg_active) begin
      curr_cfg.max_inst = '0;
      curr_cfg.max_rpt  = '0;
    end
  end

  assign seq_valid_o = ~rd_empty;
  assign seq_fire    = seq_valid_o & seq_ready_i;
  assign inst_last   = inst_cnt_q == curr_cfg.max_inst;
  assign rpt_last    = rpt_cnt_q == curr_cfg.max_rpt;
  assign loop_end    = seq_fire & inst_last & rpt_last;
  assign fifo_pop    = loop_end & cfg_active;
  assign stg_step    = (stg_cnt_q == curr_cfg.stagger_max) ? '0 : stg_cnt_q + stagger_t'(1);

  always_comb begin
    inst_cnt_d = inst_cnt_q;
    rpt_cnt_d  = rpt_cnt_q;
    stg_cnt_d  = stg_cnt_q;
    if (seq_fire) begin
      if (curr_cfg.is_outer) begin
        // Walk the body, then start the next repeat
        if (inst_last) begin
          inst_cnt_d = '0;
          rpt_cnt_d  = rpt_last ? '0 : rpt_cnt_q + rpt_t'(1);
          stg_cnt_d  = rpt_last ? '0 : stg_step;
        end else begin
          inst_cnt_d = inst_cnt_q + inst_cnt_t'(1);
        end
      end else begin
        // Repeat each instruction before moving to the next
        if (rpt_last) begin
          rpt_cnt_d  = '0;
          inst_cnt_d = inst_last ? '0 : inst_cnt_q + inst_cnt_t'(1);
          stg_cnt_d  = inst_last ? '0 : stg_step;
        end else begin
          rpt_cnt_d = rpt_cnt_q + rpt_t'(1);
          stg_cnt_d = stg_step;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q   <= '0;
      base_ptr_q <= '0;
      inst_cnt_q <= '0;
      rpt_cnt_q  <= '0;
      stg_cnt_q  <= '0;
    end else begin
      if (body_push) wr_ptr_q <= wr_ptr_q + ptr_t'(1);
      // Retire the whole body once its last copy has gone out
      if (loop_end) base_ptr_q <= base_ptr_q + ptr_t'(curr_cfg.max_inst) + ptr_t'(1);
      inst_cnt_q <= inst_cnt_d;
      rpt_cnt_q  <= rpt_cnt_d;
      stg_cnt_q  <= stg_cnt_d;
    end
  end

  // Register staggering, fields wrap modulo 32
  always_comb begin
    seq_op_o = rd_entry.op;
    if (curr_cfg.stagger_mask[0]) seq_op_o[11:7] = rd_entry.op[11:7] + 5'(stg_cnt_q);
    if (curr_cfg.stagger_mask[1]) seq_op_o[19:15] = rd_entry.op[19:15] + 5'(stg_cnt_q);
    if (curr_cfg.stagger_mask[2]) seq_op_o[24:20] = rd_entry.op[24:20] + 5'(stg_cnt_q);
    if (curr_cfg.stagger_mask[3]) seq_op_o[31:27] = rd_entry.op[31:27] + 5'(stg_cnt_q);
  end

  assign seq_argc_o = rd_entry.argc;
  assign seq_repd_o = rpt_cnt_q != '0;

endmodule

// ==== rtl/seq_cfg_fifo.sv ====
// Register FIFO for pending loop configurations
// Each entry holds a loop_cfg_t together with its ring buffer base pointer

`timescale 1ns/1ps

module seq_cfg_fifo #(
  parameter int unsigned Depth = 16,
  localparam int unsigned PtrWidth = $clog2(Depth) + 1,
  localparam int unsigned DataWidth = $bits(fpu_seq_pkg::loop_cfg_t) + PtrWidth
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [DataWidth-1:0] data_i,
  input  logic                 push_i,
  output logic                 full_o,
  output logic [DataWidth-1:0] data_o,
  output logic                 empty_o,
  input  logic                 pop_i
);

  localparam int unsigned IdxWidth = $clog2(Depth);

  logic [DataWidth-1:0] mem_q [Depth];
  logic [IdxWidth-1:0]  wr_idx_q, rd_idx_q;
  logic [IdxWidth-1:0]  wr_idx_next;
  logic                 full_q;
  logic                 do_push, do_pop;

  assign do_push     = push_i & ~full_q;
  assign do_pop      = pop_i & ~empty_o;
  assign wr_idx_next = wr_idx_q + IdxWidth'(1);
  assign empty_o     = (wr_idx_q == rd_idx_q) & ~full_q;
  assign full_o      = full_q;
  assign data_o      = mem_q[rd_idx_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_idx_q] <= data_i;
    end
  end

  // Equal indices mean full or empty, the flag tells them apart
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_idx_q <= '0;
      rd_idx_q <= '0;
      full_q   <= 1'b0;
    end else begin
      if (do_push) wr_idx_q <= wr_idx_next;
      if (do_pop) rd_idx_q <= rd_idx_q + IdxWidth'(1);
      if (do_push && !do_pop) begin
        full_q <= wr_idx_next == rd_idx_q;
      end else if (do_pop && !do_push) begin
        full_q <= 1'b0;
      end
    end
  end

endmodule

// ==== rtl/offload_decoder.sv ====
// Offload decoder
// Sorts requests into frep, direct and sequenced classes and routes the handshake

`timescale 1ns/1ps

module offload_decoder (
  input  fpu_seq_pkg::offload_req_t req_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  output fpu_seq_pkg::loop_cfg_t    cfg_o,
  output logic                      cfg_valid_o,
  input  logic                      cfg_ready_i,
  output logic                      body_valid_o,
  input  logic                      body_ready_i,
  output logic                      direct_valid_o,
  input  logic                      direct_ready_i
);
  import fpu_seq_pkg::*;

  instr_class_e instr_class;
  logic         is_sync_fp;

  // OP-FP operations that must synchronize with the integer pipeline
  always_comb begin
    is_sync_fp = 1'b0;
    for (int i = 0; i < NumSyncFunct5; i++) begin
      if (req_i.op[31:27] == Funct5Sync[i]) begin
        is_sync_fp = 1'b1;
      end
    end
  end

  always_comb begin
    case (req_i.op[6:0])
      OpcodeFrep:   instr_class = ClassFrep;
      OpcodeSystem: instr_class = ClassDirect;
      OpcodeOpFp:   instr_class = is_sync_fp ? ClassDirect : ClassSeq;
      default:      instr_class = ClassSeq;
    endcase
  end

  // Loop configuration fields of the frep header
  assign cfg_o.is_outer     = req_i.op[7];
  assign cfg_o.stagger_mask = req_i.op[11:8];
  assign cfg_o.stagger_max  = req_i.op[14:12];
  assign cfg_o.max_inst     = req_i.op[20 +: MaxInstWidth];
  assign cfg_o.max_rpt      = req_i.arga[RptWidth-1:0];

  // Only the selected branch sees valid and drives ready back
  always_comb begin
    cfg_valid_o    = 1'b0;
    body_valid_o   = 1'b0;
    direct_valid_o = 1'b0;
    req_ready_o    = 1'b0;
    case (instr_class)
      ClassFrep: begin
        cfg_valid_o = req_valid_i;
        req_ready_o = cfg_ready_i;
      end
      ClassDirect: begin
        direct_valid_o = req_valid_i;
        req_ready_o    = direct_ready_i;
      end
      default: begin
        body_valid_o = req_valid_i;
        req_ready_o  = body_ready_i;
      end
    endcase
  end

endmodule

// ==== rtl/fpu_seq_pkg.sv ====
// Widths, opcode constants and request types of the FPU offload sequencer
// Also holds the instruction class enum and the loop configuration struct

package fpu_seq_pkg;

  // Payload widths
  localparam int unsigned InstrWidth       = 32;
  localparam int unsigned OperandWidth     = 64;
  localparam int unsigned AddrWidth        = 32;
  localparam int unsigned QidWidth         = 5;
  localparam int unsigned RptWidth         = 16;
  localparam int unsigned MaxInstWidth     = 4;
  localparam int unsigned StaggerWidth     = 3;
  localparam int unsigned StaggerMaskWidth = 4;

  typedef logic [InstrWidth-1:0]       instr_t;
  typedef logic [OperandWidth-1:0]     operand_t;
  typedef logic [AddrWidth-1:0]        addr_t;
  typedef logic [QidWidth-1:0]         qid_t;
  typedef logic [RptWidth-1:0]         rpt_t;
  typedef logic [MaxInstWidth-1:0]     inst_cnt_t;
  typedef logic [StaggerWidth-1:0]     stagger_t;
  typedef logic [StaggerMaskWidth-1:0] stagger_mask_t;

  // Frep sits on custom-0 and op bit 7 selects the outer variant
  localparam logic [6:0] OpcodeFrep   = 7'b0001011;
  localparam logic [6:0] OpcodeOpFp   = 7'b1010011;
  localparam logic [6:0] OpcodeSystem = 7'b1110011;

  // OP-FP funct5 values that cross between integer and FP register files
  localparam int unsigned NumSyncFunct5 = 5;
  localparam logic [NumSyncFunct5-1:0][4:0] Funct5Sync = {
    5'b10100,  // feq, flt, fle
    5'b11100,  // fclass and fmv.x
    5'b11000,  // fcvt to integer
    5'b11110,  // fmv from integer
    5'b11010   // fcvt from integer
  };

  typedef enum logic [1:0] {
    ClassFrep,
    ClassDirect,
    ClassSeq
  } instr_class_e;

  typedef struct packed {
    instr_t   op;
    qid_t     qid;
    operand_t arga;
    operand_t argb;
    addr_t    argc;
  } offload_req_t;

  typedef struct packed {
    offload_req_t req;
    logic         repd;
  } issue_req_t;

  typedef struct packed {
    logic          is_outer;
    inst_cnt_t     max_inst;
    rpt_t          max_rpt;
    stagger_t      stagger_max;
    stagger_mask_t stagger_mask;  // rd, rs1, rs2, rs3 from bit 0 up
  } loop_cfg_t;

endpackage
